//--- ctrl_params.svh
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction field widths
`define CtrlOpWidth 6
`define CtrlFunctWidth 6

// datapath select widths
`define CtrlAluSelWidth 3
`define CtrlMemtoRegWidth 3
`define CtrlPcSourceWidth 3
`define CtrlMux2Width 2
`define CtrlStateWidth 5

`define CtrlOpRType 6'h00 // funct field selects the operation
`define CtrlOpBeq 6'h04
`define CtrlOpBne 6'h05
`define CtrlOpLw 6'h23
`define CtrlOpSw 6'h2b
`define CtrlOpLui 6'h0f
`define CtrlOpJ 6'h02

`define CtrlFnAdd 6'h20
`define CtrlFnAnd 6'h24
`define CtrlFnSub 6'h22
`define CtrlFnXor 6'h26
`define CtrlFnBreak 6'h0d
`define CtrlFnNop 6'h00

`define CtrlAluPass 3'd0
`define CtrlAluAdd 3'd1
`define CtrlAluSub 3'd2
`define CtrlAluAnd 3'd3
`define CtrlAluXor 3'd6

`endif

//--- ctrl_pkg.sv
`default_nettype none

`include "ctrl_params.svh"

package ctrl_pkg;

	typedef logic [`CtrlOpWidth-1:0] opcodeT;
	typedef logic [`CtrlFunctWidth-1:0] functT;

	typedef logic [`CtrlAluSelWidth-1:0] aluSelT;
	typedef logic [`CtrlMemtoRegWidth-1:0] memtoRegT; // register write data source
	typedef logic [`CtrlPcSourceWidth-1:0] pcSourceT; // next pc source
	typedef logic [`CtrlMux2Width-1:0] mux2SelT; // alu b, address and destination selects

	// decoded instruction, unknown ones fold into Nop
	typedef enum logic [3:0]
	{
		Add,
		And,
		Sub,
		Xor,
		Break,
		Nop,
		Beq,
		Bne,
		Lw,
		Sw,
		Lui,
		Jump
	} instrClassT;

	typedef enum logic [`CtrlStateWidth-1:0]
	{
		StReset,
		StFetch,
		StFetchWait1, // memory read latency
		StFetchWait2,
		StDecode,
		StAdd,
		StAnd,
		StSub,
		StXor,
		StRWait, // r-type write-back
		StBreak, // halts until reset
		StNop,
		StBeq,
		StBne,
		StJump,
		StLui,
		StLwAddr,
		StLw,
		StLwWait1,
		StLwWait2,
		StWriteBack,
		StSwAddr,
		StSw
	} ctrlStateT;

	typedef struct packed
	{
		logic regClear; // clears all datapath registers and register file
		logic pcWrite;
		logic pcWriteCond; // pc load qualified by alu zero
		logic memWrite;
		logic irWrite;
		logic regWrite;
		aluSelT aluSel;
		memtoRegT memtoReg;
		pcSourceT pcSource;
		logic aluSrcA; // 0 pc, 1 register a
		mux2SelT aluSrcB;
		mux2SelT iorD; // 0 instruction, 1 data address
		mux2SelT regDst;
		logic aLoad;
		logic bLoad;
		logic mdrLoad;
		logic aluOutLoad;
	} ctrlWordT;

endpackage : ctrl_pkg

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_params.svh"

module instr_decoder
(
	input wire ctrl_pkg::opcodeT Op,
	input wire ctrl_pkg::functT Funct,
	output ctrl_pkg::instrClassT instrClass
);

	ctrl_pkg::instrClassT rTypeClass;

	always_comb
	begin
		case (Funct)
			`CtrlFnAdd: rTypeClass = ctrl_pkg::Add;
			`CtrlFnAnd: rTypeClass = ctrl_pkg::And;
			`CtrlFnSub: rTypeClass = ctrl_pkg::Sub;
			`CtrlFnXor: rTypeClass = ctrl_pkg::Xor;
			`CtrlFnBreak: rTypeClass = ctrl_pkg::Break;
			`CtrlFnNop: rTypeClass = ctrl_pkg::Nop;
			default: rTypeClass = ctrl_pkg::Nop; // unknown funct behaves as nop
		endcase
	end

	always_comb
	begin
		case (Op)
			`CtrlOpRType:
			begin
				instrClass = rTypeClass; // funct only matters here
			end
			`CtrlOpBeq: instrClass = ctrl_pkg::Beq;
			`CtrlOpBne: instrClass = ctrl_pkg::Bne;
			`CtrlOpLw: instrClass = ctrl_pkg::Lw;
			`CtrlOpSw: instrClass = ctrl_pkg::Sw;
			`CtrlOpLui: instrClass = ctrl_pkg::Lui;
			`CtrlOpJ: instrClass = ctrl_pkg::Jump;
			default:
			begin
				instrClass = ctrl_pkg::Nop; // unknown opcode
			end
		endcase
	end

endmodule : instr_decoder

`default_nettype wire

//--- state_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module state_sequencer
(
	input wire logic Clk,
	input wire logic Reset_signal,
	input wire ctrl_pkg::instrClassT instrClass,
	output ctrl_pkg::ctrlStateT state
);

	ctrl_pkg::ctrlStateT nextState;
	ctrl_pkg::ctrlStateT decodeTarget;

	// branch target out of decode
	always_comb
	begin
		case (instrClass)
			ctrl_pkg::Add: decodeTarget = ctrl_pkg::StAdd;
			ctrl_pkg::And: decodeTarget = ctrl_pkg::StAnd;
			ctrl_pkg::Sub: decodeTarget = ctrl_pkg::StSub;
			ctrl_pkg::Xor: decodeTarget = ctrl_pkg::StXor;
			ctrl_pkg::Break: decodeTarget = ctrl_pkg::StBreak;
			ctrl_pkg::Beq: decodeTarget = ctrl_pkg::StBeq;
			ctrl_pkg::Bne: decodeTarget = ctrl_pkg::StBne;
			ctrl_pkg::Lw: decodeTarget = ctrl_pkg::StLwAddr; // address first
			ctrl_pkg::Sw: decodeTarget = ctrl_pkg::StSwAddr;
			ctrl_pkg::Lui: decodeTarget = ctrl_pkg::StLui;
			ctrl_pkg::Jump: decodeTarget = ctrl_pkg::StJump;
			default: decodeTarget = ctrl_pkg::StNop;
		endcase
	end

	always_comb
	begin
		case (state)
			ctrl_pkg::StReset: nextState = ctrl_pkg::StFetch;
			ctrl_pkg::StFetch: nextState = ctrl_pkg::StFetchWait1;
			ctrl_pkg::StFetchWait1: nextState = ctrl_pkg::StFetchWait2;
			ctrl_pkg::StFetchWait2: nextState = ctrl_pkg::StDecode;
			ctrl_pkg::StDecode:
			begin
				nextState = decodeTarget; // class only sampled here
			end
			ctrl_pkg::StAdd,
			ctrl_pkg::StAnd,
			ctrl_pkg::StSub,
			ctrl_pkg::StXor:
			begin
				nextState = ctrl_pkg::StRWait;
			end
			ctrl_pkg::StBreak: nextState = ctrl_pkg::StBreak; // wait for reset
			ctrl_pkg::StLwAddr: nextState = ctrl_pkg::StLw;
			ctrl_pkg::StLw: nextState = ctrl_pkg::StLwWait1;
			ctrl_pkg::StLwWait1: nextState = ctrl_pkg::StLwWait2;
			ctrl_pkg::StLwWait2: nextState = ctrl_pkg::StWriteBack;
			ctrl_pkg::StSwAddr: nextState = ctrl_pkg::StSw;
			ctrl_pkg::StRWait,
			ctrl_pkg::StNop,
			ctrl_pkg::StBeq,
			ctrl_pkg::StBne,
			ctrl_pkg::StJump,
			ctrl_pkg::StLui,
			ctrl_pkg::StWriteBack,
			ctrl_pkg::StSw:
			begin
				nextState = ctrl_pkg::StFetch; // instruction done
			end
			default:
			begin
				nextState = ctrl_pkg::StReset; // illegal code recovers through reset
			end
		endcase
	end

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
		begin
			state <= ctrl_pkg::StReset;
		end
		else
		begin
			state <= nextState;
		end
	end

endmodule : state_sequencer

`default_nettype wire

//--- control_word_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_params.svh"

module control_word_gen
(
	input wire ctrl_pkg::ctrlStateT state,
	input wire logic AluZero,
	output ctrl_pkg::ctrlWordT CtrlWord,
	output logic PcLoad
);

	logic zeroQual;

	always_comb
	begin
		CtrlWord = '0; // idle word, also used by nop and break
		case (state)
			ctrl_pkg::StReset:
			begin
				CtrlWord.regClear = 1'b1;
			end
			ctrl_pkg::StFetch,
			ctrl_pkg::StFetchWait1:
			begin
				CtrlWord.aluSrcB = 2'd1; // pc + 4 prepared while memory reads
			end
			ctrl_pkg::StFetchWait2:
			begin
				CtrlWord.pcWrite = 1'b1; // pc <= pc + 4
				CtrlWord.irWrite = 1'b1;
				CtrlWord.mdrLoad = 1'b1;
				CtrlWord.aluSel = `CtrlAluAdd;
				CtrlWord.aluSrcB = 2'd1;
			end
			ctrl_pkg::StDecode:
			begin
				CtrlWord.aLoad = 1'b1;
				CtrlWord.bLoad = 1'b1;
				CtrlWord.aluSel = `CtrlAluAdd; // branch target pc + offset
				CtrlWord.aluSrcB = 2'd3; // shifted sign-extended offset
				CtrlWord.aluOutLoad = 1'b1;
			end
			ctrl_pkg::StAdd:
			begin
				CtrlWord.aluSel = `CtrlAluAdd;
				CtrlWord.aluSrcA = 1'b1;
				CtrlWord.aluOutLoad = 1'b1;
			end
			ctrl_pkg::StAnd:
			begin
				CtrlWord.aluSel = `CtrlAluAnd;
				CtrlWord.aluSrcA = 1'b1;
				CtrlWord.aluOutLoad = 1'b1;
			end
			ctrl_pkg::StSub:
			begin
				CtrlWord.aluSel = `CtrlAluSub;
				CtrlWord.aluSrcA = 1'b1;
				CtrlWord.aluOutLoad = 1'b1;
			end
			ctrl_pkg::StXor:
			begin
				CtrlWord.aluSel = `CtrlAluXor;
				CtrlWord.aluSrcA = 1'b1;
				CtrlWord.aluOutLoad = 1'b1;
			end
			ctrl_pkg::StRWait:
			begin
				CtrlWord.regWrite = 1'b1;
				CtrlWord.regDst = 2'd1; // rd field
			end
			ctrl_pkg::StBeq,
			ctrl_pkg::StBne:
			begin
				CtrlWord.pcWriteCond = 1'b1;
				CtrlWord.aluSel = `CtrlAluSub; // compare a and b
				CtrlWord.aluSrcA = 1'b1;
				CtrlWord.pcSource = 3'd1; // target held in aluout
			end
			ctrl_pkg::StJump:
			begin
				CtrlWord.pcWrite = 1'b1;
				CtrlWord.pcSource = 3'd2; // pc upper bits with index
				CtrlWord.aluSel = `CtrlAluAdd;
				CtrlWord.aluSrcB = 2'd3;
				CtrlWord.iorD = 2'd1;
				CtrlWord.aluOutLoad = 1'b1;
			end
			ctrl_pkg::StLui:
			begin
				CtrlWord.regWrite = 1'b1; // into rt
				CtrlWord.memtoReg = 3'd2; // upper immediate
			end
			ctrl_pkg::StLwAddr,
			ctrl_pkg::StSwAddr:
			begin
				CtrlWord.aluSel = `CtrlAluAdd; // base plus offset
				CtrlWord.aluSrcA = 1'b1;
				CtrlWord.aluSrcB = 2'd2;
				CtrlWord.aluOutLoad = 1'b1;
			end
			ctrl_pkg::StSw:
			begin
				CtrlWord.memWrite = 1'b1;
				CtrlWord.iorD = 2'd1;
			end
			ctrl_pkg::StLw,
			ctrl_pkg::StLwWait1,
			ctrl_pkg::StLwWait2:
			begin
				CtrlWord.mdrLoad = 1'b1; // hold the data read
				CtrlWord.iorD = 2'd1;
			end
			ctrl_pkg::StWriteBack:
			begin
				CtrlWord.regWrite = 1'b1;
				CtrlWord.memtoReg = 3'd1; // mdr into rt
			end
			default:
			begin
				CtrlWord.aluSel = `CtrlAluPass;
			end
		endcase
	end

	// bne takes the branch when the difference is nonzero
	assign zeroQual = (state == ctrl_pkg::StBne) ? ~AluZero : AluZero;
	assign PcLoad = CtrlWord.pcWrite | (CtrlWord.pcWriteCond & zeroQual);

endmodule : control_word_gen

`default_nettype wire

//--- mips_control.sv
`timescale 1ns/100ps
`default_nettype none

module mips_control
(
	input wire logic Clk,
	input wire logic Reset_signal,
	input wire ctrl_pkg::opcodeT Op,
	input wire ctrl_pkg::functT Funct,
	input wire logic AluZero, // zero flag of the datapath alu
	output ctrl_pkg::ctrlWordT CtrlWord,
	output logic PcLoad,
	output ctrl_pkg::ctrlStateT State
);

	ctrl_pkg::instrClassT instrClass;

	instr_decoder decoder
	(
		.Op(Op),
		.Funct(Funct),
		.instrClass(instrClass)
	);

	state_sequencer sequencer
	(
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.instrClass(instrClass),
		.state(State) // also exported for observation
	);

	control_word_gen wordGen
	(
		.state(State),
		.AluZero(AluZero),
		.CtrlWord(CtrlWord),
		.PcLoad(PcLoad)
	);

endmodule : mips_control

`default_nettype wire

//--- mips_control_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module mips_control_assertions
(
	input wire logic Clk,
	input wire logic Reset_signal,
	input wire ctrl_pkg::ctrlWordT CtrlWord,
	input wire logic PcLoad,
	input wire ctrl_pkg::ctrlStateT State
);

	// datapath clear belongs to the reset state alone
	property clearOnlyInReset;
		@(posedge Clk) CtrlWord.regClear |-> (State == ctrl_pkg::StReset);
	endproperty

	property noWriteOverlap;
		@(posedge Clk) !(CtrlWord.memWrite && CtrlWord.regWrite);
	endproperty

	// halted unit must not move the pc
	property quietBreak;
		@(posedge Clk) disable iff (Reset_signal)
			(State == ctrl_pkg::StBreak) |-> !$rose(PcLoad);
	endproperty

	clearCheck: assert property (clearOnlyInReset)
		else $error("register clear active outside the reset state");

	writeCheck: assert property (noWriteOverlap)
		else $error("memory write and register write active together");

	breakCheck: assert property (quietBreak)
		else $error("pc load rose while halted in break");

endmodule : mips_control_assertions

bind mips_control mips_control_assertions assertChecks
(
	.Clk(Clk),
	.Reset_signal(Reset_signal),
	.CtrlWord(CtrlWord),
	.PcLoad(PcLoad),
	.State(State)
);

`default_nettype wire

//--- tb_mips_control.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips_control;

	logic Clk;
	logic Reset_signal;
	ctrl_pkg::opcodeT Op;
	ctrl_pkg::functT Funct;
	logic AluZero;
	ctrl_pkg::ctrlWordT ctrlWord;
	logic pcLoad;
	ctrl_pkg::ctrlStateT state;

	// one entry per data line
	string names[$];
	ctrl_pkg::opcodeT opList[$];
	ctrl_pkg::functT functList[$];
	logic zeroList[$];
	int cycleExp[$]; // 0 marks a halting instruction
	ctrl_pkg::aluSelT aluExp[$];
	logic pcLoadExp[$];
	int regWriteExp[$];
	int memWriteExp[$];

	int watchCycles; // stays 0 until the tests are loaded

	mips_control DUT
	(
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.Op(Op),
		.Funct(Funct),
		.AluZero(AluZero),
		.CtrlWord(ctrlWord),
		.PcLoad(pcLoad),
		.State(state)
	);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk; // 4 ns period
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic checkState(input string tName, input ctrl_pkg::ctrlStateT expVal,
		input ctrl_pkg::ctrlStateT actVal);
		if (actVal !== expVal)
			failRun($sformatf("mismatch %s: expected %s actual %s", tName, expVal.name(),
				actVal.name()));
	endtask

	task automatic checkAluSel(input string tName, input ctrl_pkg::aluSelT expVal,
		input ctrl_pkg::aluSelT actVal);
		if (actVal !== expVal)
			failRun($sformatf("mismatch %s: expected %0d actual %0d", tName, expVal, actVal));
	endtask

	task automatic checkBit(input string tName, input logic expVal, input logic actVal);
		if (actVal !== expVal)
			failRun($sformatf("mismatch %s: expected %b actual %b", tName, expVal, actVal));
	endtask

	task automatic checkCount(input string tName, input int expVal, input int actVal);
		if (actVal !== expVal)
			failRun($sformatf("mismatch %s: expected %0d actual %0d", tName, expVal, actVal));
	endtask

	// every strobe and load low, pc load included
	task automatic checkIdle(input string tName);
		checkBit({tName, " pcWrite"}, 1'b0, ctrlWord.pcWrite);
		checkBit({tName, " pcWriteCond"}, 1'b0, ctrlWord.pcWriteCond);
		checkBit({tName, " memWrite"}, 1'b0, ctrlWord.memWrite);
		checkBit({tName, " irWrite"}, 1'b0, ctrlWord.irWrite);
		checkBit({tName, " regWrite"}, 1'b0, ctrlWord.regWrite);
		checkBit({tName, " aLoad"}, 1'b0, ctrlWord.aLoad);
		checkBit({tName, " bLoad"}, 1'b0, ctrlWord.bLoad);
		checkBit({tName, " mdrLoad"}, 1'b0, ctrlWord.mdrLoad);
		checkBit({tName, " aluOutLoad"}, 1'b0, ctrlWord.aluOutLoad);
		checkBit({tName, " PcLoad"}, 1'b0, pcLoad);
	endtask

	task automatic loadTests();
		int fd;
		int got;
		string line;
		string tName;
		ctrl_pkg::opcodeT tOp;
		ctrl_pkg::functT tFunct;
		logic tZero;
		int tCycles;
		ctrl_pkg::aluSelT tAlu;
		logic tPc;
		int tReg;
		int tMem;
		fd = $fopen("control_input.dat", "r");
		if (fd == 0)
			failRun("could not open the data file control_input.dat");
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 4 || line.getc(0) == "#")
				continue; // blank or comment
			got = $sscanf(line, "%s %h %h %b %d %h %b %d %d", tName, tOp, tFunct, tZero,
				tCycles, tAlu, tPc, tReg, tMem);
			if (got != 9)
				failRun({"badly formed data line: ", line});
			names.push_back(tName);
			opList.push_back(tOp);
			functList.push_back(tFunct);
			zeroList.push_back(tZero);
			cycleExp.push_back(tCycles);
			aluExp.push_back(tAlu);
			pcLoadExp.push_back(tPc);
			regWriteExp.push_back(tReg);
			memWriteExp.push_back(tMem);
		end
		$fclose(fd);
		if (names.size() == 0)
			failRun("the data file holds no tests");
	endtask

	// ends at 0.5 ns after the edge that enters fetch
	task automatic applyReset(input string tName);
		@(posedge Clk);
		#0.5;
		Reset_signal = 1'b1;
		repeat (4)
		begin
			@(negedge Clk);
			checkState({tName, " state"}, ctrl_pkg::StReset, state);
			checkBit({tName, " regClear"}, 1'b1, ctrlWord.regClear);
			checkIdle(tName);
			checkAluSel({tName, " aluSel"}, 3'd0, ctrlWord.aluSel);
			checkBit({tName, " selects"}, 1'b0, |{ctrlWord.memtoReg, ctrlWord.pcSource,
				ctrlWord.aluSrcA, ctrlWord.aluSrcB, ctrlWord.iorD, ctrlWord.regDst});
		end
		@(posedge Clk);
		#0.5;
		Reset_signal = 1'b0;
		@(negedge Clk);
		checkState({tName, " release"}, ctrl_pkg::StReset, state);
		@(posedge Clk);
		#0.5;
		checkState({tName, " first fetch"}, ctrl_pkg::StFetch, state);
	endtask

	// entered just after the edge into fetch
	task automatic runInstr(input int idx);
		ctrl_pkg::ctrlStateT prevState;
		int cycles;
		int regWrites;
		int memWrites;
		logic done;
		Op = opList[idx];
		Funct = functList[idx];
		AluZero = zeroList[idx];
		prevState = ctrl_pkg::StReset;
		cycles = 0;
		regWrites = 0;
		memWrites = 0;
		done = 1'b0;
		while (!done)
		begin
			@(negedge Clk);
			if (prevState == ctrl_pkg::StDecode)
			begin
				checkAluSel({names[idx], " aluSel"}, aluExp[idx], ctrlWord.aluSel);
				checkBit({names[idx], " PcLoad"}, pcLoadExp[idx], pcLoad);
			end
			regWrites += ctrlWord.regWrite;
			memWrites += ctrlWord.memWrite;
			prevState = state;
			cycles++;
			@(posedge Clk);
			#0.5;
			if (state == ctrl_pkg::StFetch)
				done = 1'b1;
			else if (cycles > 16)
				failRun({names[idx], " never returned to the fetch state"});
		end
		checkCount({names[idx], " cycles"}, cycleExp[idx], cycles);
		checkCount({names[idx], " regWrite cycles"}, regWriteExp[idx], regWrites);
		checkCount({names[idx], " memWrite cycles"}, memWriteExp[idx], memWrites);
	endtask

	task automatic runHalt(input int idx);
		int waited;
		Op = opList[idx];
		Funct = functList[idx];
		AluZero = zeroList[idx];
		waited = 0;
		while (state != ctrl_pkg::StBreak)
		begin
			@(posedge Clk);
			#0.5;
			waited++;
			if (waited > 8)
				failRun({names[idx], " never reached the break state"});
		end
		repeat (10)
		begin
			@(negedge Clk);
			checkState({names[idx], " halted"}, ctrl_pkg::StBreak, state);
			checkIdle(names[idx]);
		end
		applyReset({names[idx], " recovery"});
	endtask

	initial
	begin
		wait (watchCycles > 0);
		repeat (watchCycles) @(posedge Clk);
		failRun("watchdog timeout, the tests did not finish in time");
	end

	initial
	begin
		int i;
		Reset_signal = 1'b1;
		Op = '0;
		Funct = '0;
		AluZero = 1'b0;
		loadTests();
		watchCycles = names.size() * 12 + 20;
		applyReset("initial reset");
		for (i = 0; i < names.size(); i++)
		begin
			if (cycleExp[i] == 0)
				runHalt(i);
			else
				runInstr(i);
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule : tb_mips_control

`default_nettype wire

//--- control_input.dat
# name op funct aluZero cycles aluSel pcLoad regWrites memWrites (op funct aluSel in hex)
# cycles counts fetch back to fetch, 0 means halt; aluSel and pcLoad seen after decode
# r-type arithmetic
add       00 20 0 6 1 0 1 0
and       00 24 0 6 3 0 1 0
sub       00 22 0 6 2 0 1 0
xor       00 26 0 6 6 0 1 0
add_zero  00 20 1 6 1 0 1 0
xor_zero  00 26 1 6 6 0 1 0

# conditional branches, both zero flag values
beq_nz    04 00 0 5 2 0 0 0
beq_z     04 00 1 5 2 1 0 0
bne_nz    05 00 0 5 2 1 0 0
bne_z     05 00 1 5 2 0 0 0

# jump loads the pc regardless of the flag
j         02 00 0 5 1 1 0 0
j_zero    02 00 1 5 1 1 0 0

# memory access
lw        23 00 0 9 1 0 1 0
sw        2b 00 0 6 1 0 0 1
lw_zero   23 00 1 9 1 0 1 0
sw_zero   2b 00 1 6 1 0 0 1

# immediate and no-op forms
lui       0f 00 0 5 0 0 1 0
lui_zero  0f 00 1 5 0 0 1 0
nop       00 00 0 5 0 0 0 0
nop_zero  00 00 1 5 0 0 0 0

# unknown encodings fall back to nop
bad_op    3f 00 0 5 0 0 0 0
bad_op2   11 20 1 5 0 0 0 0
bad_funct 00 3a 0 5 0 0 0 0

# halt, then reset and resume
break     00 0d 0 0 0 0 0 0
add_after 00 20 0 6 1 0 1 0
beq_after 04 00 1 5 2 1 0 0

//--- sources.f
+incdir+.
ctrl_pkg.sv
instr_decoder.sv
state_sequencer.sv
control_word_gen.sv
mips_control.sv
mips_control_assertions.sv
tb_mips_control.sv
